// ==== filelist.f ====
source/hawk_pkg.sv
source/hawk_xlate_if.sv
source/hawk_cpu_stall_wr.sv
source/hawk_page_table.sv
source/hawk_wr_top.sv
tests/tb_hawk_checks.sv
tests/tb_hawk_wr.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the write path testbench with Verilator
rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module tb_hawk_wr \
   -o sim_hawk_wr > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_hawk_wr > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0

// ==== source/hawk_cpu_stall_wr.sv ====
// Write address stall block
// Holds each CPU AW until its page is translated, then reissues it
// on the master AW channel. W and B pass straight through
`timescale 1ns/1ps

module hawk_cpu_stall_wr (
   input  logic                             clk,
   input  logic                             rst,

   hawk_xlate_if.stall                      xl,

   // AXI slave side
   input  logic [hawk_pkg::ID_WIDTH-1:0]    s_axi_awid,
   input  logic [hawk_pkg::ADDR_WIDTH-1:0]  s_axi_awaddr,
   input  logic [7:0]                       s_axi_awlen,
   input  logic [2:0]                       s_axi_awsize,
   input  logic [1:0]                       s_axi_awburst,
   input  logic                             s_axi_awvalid,
   output logic                             s_axi_awready,
   input  logic [hawk_pkg::DATA_WIDTH-1:0]  s_axi_wdata,
   input  logic [hawk_pkg::STRB_WIDTH-1:0]  s_axi_wstrb,
   input  logic                             s_axi_wlast,
   input  logic                             s_axi_wvalid,
   output logic                             s_axi_wready,
   output logic [hawk_pkg::ID_WIDTH-1:0]    s_axi_bid,
   output logic [1:0]                       s_axi_bresp,
   output logic                             s_axi_bvalid,
   input  logic                             s_axi_bready,

   // AXI master side
   output logic [hawk_pkg::ID_WIDTH-1:0]    m_axi_awid,
   output logic [hawk_pkg::ADDR_WIDTH-1:0]  m_axi_awaddr,
   output logic [7:0]                       m_axi_awlen,
   output logic [2:0]                       m_axi_awsize,
   output logic [1:0]                       m_axi_awburst,
   output logic                             m_axi_awvalid,
   input  logic                             m_axi_awready,
   output logic [hawk_pkg::DATA_WIDTH-1:0]  m_axi_wdata,
   output logic [hawk_pkg::STRB_WIDTH-1:0]  m_axi_wstrb,
   output logic                             m_axi_wlast,
   output logic                             m_axi_wvalid,
   input  logic                             m_axi_wready,
   input  logic [hawk_pkg::ID_WIDTH-1:0]    m_axi_bid,
   input  logic [1:0]                       m_axi_bresp,
   input  logic                             m_axi_bvalid,
   output logic                             m_axi_bready
);

   hawk_pkg::stall_state_e state_q;
   hawk_pkg::stall_state_e state_d;

   logic awready_q;
   logic awready_d;
   logic awvalid_q;
   logic awvalid_d;
   logic allow_q;
   logic aw_capture;
   logic aw_issue;

   // Held AW fields
   logic [hawk_pkg::ID_WIDTH-1:0] id_q;
   hawk_pkg::axi_addr_u           addr_q;
   logic [7:0]                    len_q;
   logic [2:0]                    size_q;
   logic [1:0]                    burst_q;

   assign aw_capture = s_axi_awvalid && awready_q;
   // Translation granted, address goes out on this edge
   assign aw_issue   = (state_q == hawk_pkg::WAIT) && allow_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         hawk_pkg::IDLE: begin
            if (aw_capture) begin
               state_d = hawk_pkg::WAIT;
            end
         end
         hawk_pkg::WAIT: begin
            if (allow_q) begin
               state_d = hawk_pkg::IDLE;
            end
         end
         default: state_d = hawk_pkg::IDLE;
      endcase
   end

   always_comb begin
      awvalid_d = awvalid_q && !m_axi_awready;
      if (aw_issue) begin
         awvalid_d = 1'b1;
      end
      // One address in flight at most
      awready_d = (state_d == hawk_pkg::IDLE) && !awvalid_d;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q   <= hawk_pkg::IDLE;
         awready_q <= 1'b0;
         awvalid_q <= 1'b0;
         allow_q   <= 1'b0;
      end else begin
         state_q   <= state_d;
         awready_q <= awready_d;
         awvalid_q <= awvalid_d;
         // New address waits for its own grant
         if (aw_capture) begin
            allow_q <= 1'b0;
         end else if (xl.allow_access) begin
            allow_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (aw_capture) begin
         id_q       <= s_axi_awid;
         addr_q.raw <= s_axi_awaddr;
         len_q      <= s_axi_awlen;
         size_q     <= s_axi_awsize;
         burst_q    <= s_axi_awburst;
      end else if (aw_issue) begin
         // Physical page in, offset kept
         addr_q.fields.page <= xl.ppa_page;
      end
   end

   // Lookup drops as soon as the grant shows up
   assign xl.lookup_valid = (state_q == hawk_pkg::WAIT) && !allow_q && !xl.allow_access;
   assign xl.lookup_page  = addr_q.fields.page;

   assign s_axi_awready = awready_q;
   assign m_axi_awvalid = awvalid_q;
   assign m_axi_awid    = id_q;
   assign m_axi_awaddr  = addr_q.raw;
   assign m_axi_awlen   = len_q;
   assign m_axi_awsize  = size_q;
   assign m_axi_awburst = burst_q;

   // W channel
   assign m_axi_wdata  = s_axi_wdata;
   assign m_axi_wstrb  = s_axi_wstrb;
   assign m_axi_wlast  = s_axi_wlast;
   assign m_axi_wvalid = s_axi_wvalid;
   assign s_axi_wready = m_axi_wready;

   // B channel
   assign s_axi_bid    = m_axi_bid;
   assign s_axi_bresp  = m_axi_bresp;
   assign s_axi_bvalid = m_axi_bvalid;
   assign m_axi_bready = s_axi_bready;

   // Master AW held until accepted
   a_aw_hold: assert property (@(posedge clk) disable iff (rst)
      m_axi_awvalid && !m_axi_awready |=>
         m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awid)
         && $stable(m_axi_awlen));

   // Lookup raised in WAIT on the cycle after the CPU address is taken
   a_lookup_in_wait: assert property (@(posedge clk) disable iff (rst)
      aw_capture |=> state_q == hawk_pkg::WAIT && xl.lookup_valid);

endmodule

// ==== source/hawk_page_table.sv ====
// Direct-mapped page translation table
// Filled from outside, answers stall lookups one cycle later,
// grants everything unchanged while inactive
`timescale 1ns/1ps

module hawk_page_table (
   input  logic                             clk,
   input  logic                             rst,

   hawk_xlate_if.tbl                        xl,

   input  logic                             fill_valid,
   input  logic [hawk_pkg::PAGE_WIDTH-1:0]  fill_page,
   input  logic [hawk_pkg::PAGE_WIDTH-1:0]  fill_ppa,
   input  logic                             inactive
);

   // Entry storage
   logic [hawk_pkg::TABLE_DEPTH-1:0] valid_q;
   logic [hawk_pkg::TAG_WIDTH-1:0]   tag_mem [hawk_pkg::TABLE_DEPTH];
   logic [hawk_pkg::PAGE_WIDTH-1:0]  ppa_mem [hawk_pkg::TABLE_DEPTH];

   logic [hawk_pkg::TABLE_DEPTH_LOG2-1:0] fill_idx;
   logic [hawk_pkg::TAG_WIDTH-1:0]        fill_tag;
   logic [hawk_pkg::TABLE_DEPTH_LOG2-1:0] look_idx;
   logic [hawk_pkg::TAG_WIDTH-1:0]        look_tag;

   logic                             entry_hit;
   logic                             hit;
   logic                             grant;
   logic                             allow_q;
   logic [hawk_pkg::PAGE_WIDTH-1:0]  ppa_q;

   // Index from the low page bits, tag from the rest
   assign fill_idx = fill_page[hawk_pkg::TABLE_DEPTH_LOG2-1:0];
   assign fill_tag = fill_page[hawk_pkg::PAGE_WIDTH-1:hawk_pkg::TABLE_DEPTH_LOG2];
   assign look_idx = xl.lookup_page[hawk_pkg::TABLE_DEPTH_LOG2-1:0];
   assign look_tag = xl.lookup_page[hawk_pkg::PAGE_WIDTH-1:hawk_pkg::TABLE_DEPTH_LOG2];

   assign entry_hit = valid_q[look_idx] && (tag_mem[look_idx] == look_tag);
   assign hit       = inactive || entry_hit;

   // Misses retry every cycle until the entry is filled
   assign grant = xl.lookup_valid && hit;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
      end else if (fill_valid) begin
         valid_q[fill_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_valid) begin
         tag_mem[fill_idx] <= fill_tag;
         ppa_mem[fill_idx] <= fill_ppa;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         allow_q <= 1'b0;
      end else begin
         allow_q <= grant;
      end
   end

   // Physical page stays put until the next grant
   always_ff @(posedge clk) begin
      if (grant) begin
         ppa_q <= inactive ? xl.lookup_page : ppa_mem[look_idx];
      end
   end

   assign xl.allow_access = allow_q;
   assign xl.ppa_page     = ppa_q;

   a_single_pulse: assert property (@(posedge clk) disable iff (rst)
      xl.allow_access |=> !xl.allow_access);

endmodule

// ==== source/hawk_pkg.sv ====
// Widths of the AXI write path and of the page translation,
// the stall FSM state encoding and the two-view address word
package hawk_pkg;

   // AXI bus widths
   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 64;
   localparam int STRB_WIDTH = DATA_WIDTH / 8;
   localparam int ID_WIDTH   = 4;

   // 4 KB host pages
   localparam int PAGE_SHIFT = 12;
   localparam int PAGE_WIDTH = ADDR_WIDTH - PAGE_SHIFT;

   // Translation table geometry
   localparam int TABLE_DEPTH_LOG2 = 4;
   localparam int TABLE_DEPTH      = 1 << TABLE_DEPTH_LOG2;
   // Page bits above the index are kept as the tag
   localparam int TAG_WIDTH        = PAGE_WIDTH - TABLE_DEPTH_LOG2;

   // Page view of an address
   typedef struct packed {
      logic [PAGE_WIDTH-1:0] page;
      logic [PAGE_SHIFT-1:0] offset;
   } axi_addr_s;

   // One address word, seen either as the raw AXI address
   // or split into page number and offset
   typedef union packed {
      logic [ADDR_WIDTH-1:0] raw;
      axi_addr_s             fields;
   } axi_addr_u;

   // Stall FSM
   // IDLE accepts a new AW, WAIT holds it until translated
   typedef enum logic {
      IDLE = 1'b0,
      WAIT = 1'b1
   } stall_state_e;

endpackage

// ==== source/hawk_wr_top.sv ====
// Write path top level
// Plain AXI slave and master ports, table fill port and inactive,
// with the stall block and the translation table behind them
`timescale 1ns/1ps

module hawk_wr_top (
   input  logic                             clk,
   input  logic                             rst,

   // CPU side
   input  logic [hawk_pkg::ID_WIDTH-1:0]    s_axi_awid,
   input  logic [hawk_pkg::ADDR_WIDTH-1:0]  s_axi_awaddr,
   input  logic [7:0]                       s_axi_awlen,
   input  logic [2:0]                       s_axi_awsize,
   input  logic [1:0]                       s_axi_awburst,
   input  logic                             s_axi_awvalid,
   output logic                             s_axi_awready,
   input  logic [hawk_pkg::DATA_WIDTH-1:0]  s_axi_wdata,
   input  logic [hawk_pkg::STRB_WIDTH-1:0]  s_axi_wstrb,
   input  logic                             s_axi_wlast,
   input  logic                             s_axi_wvalid,
   output logic                             s_axi_wready,
   output logic [hawk_pkg::ID_WIDTH-1:0]    s_axi_bid,
   output logic [1:0]                       s_axi_bresp,
   output logic                             s_axi_bvalid,
   input  logic                             s_axi_bready,

   // Memory side
   output logic [hawk_pkg::ID_WIDTH-1:0]    m_axi_awid,
   output logic [hawk_pkg::ADDR_WIDTH-1:0]  m_axi_awaddr,
   output logic [7:0]                       m_axi_awlen,
   output logic [2:0]                       m_axi_awsize,
   output logic [1:0]                       m_axi_awburst,
   output logic                             m_axi_awvalid,
   input  logic                             m_axi_awready,
   output logic [hawk_pkg::DATA_WIDTH-1:0]  m_axi_wdata,
   output logic [hawk_pkg::STRB_WIDTH-1:0]  m_axi_wstrb,
   output logic                             m_axi_wlast,
   output logic                             m_axi_wvalid,
   input  logic                             m_axi_wready,
   input  logic [hawk_pkg::ID_WIDTH-1:0]    m_axi_bid,
   input  logic [1:0]                       m_axi_bresp,
   input  logic                             m_axi_bvalid,
   output logic                             m_axi_bready,

   // Table fill and bypass
   input  logic                             fill_valid,
   input  logic [hawk_pkg::PAGE_WIDTH-1:0]  fill_page,
   input  logic [hawk_pkg::PAGE_WIDTH-1:0]  fill_ppa,
   input  logic                             inactive
);

   hawk_xlate_if xl0 ();

   hawk_cpu_stall_wr stall0 (
      .clk           (clk),
      .rst           (rst),
      .xl            (xl0.stall),
      .s_axi_awid    (s_axi_awid),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awlen   (s_axi_awlen),
      .s_axi_awsize  (s_axi_awsize),
      .s_axi_awburst (s_axi_awburst),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wstrb   (s_axi_wstrb),
      .s_axi_wlast   (s_axi_wlast),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bid     (s_axi_bid),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .m_axi_awid    (m_axi_awid),
      .m_axi_awaddr  (m_axi_awaddr),
      .m_axi_awlen   (m_axi_awlen),
      .m_axi_awsize  (m_axi_awsize),
      .m_axi_awburst (m_axi_awburst),
      .m_axi_awvalid (m_axi_awvalid),
      .m_axi_awready (m_axi_awready),
      .m_axi_wdata   (m_axi_wdata),
      .m_axi_wstrb   (m_axi_wstrb),
      .m_axi_wlast   (m_axi_wlast),
      .m_axi_wvalid  (m_axi_wvalid),
      .m_axi_wready  (m_axi_wready),
      .m_axi_bid     (m_axi_bid),
      .m_axi_bresp   (m_axi_bresp),
      .m_axi_bvalid  (m_axi_bvalid),
      .m_axi_bready  (m_axi_bready)
   );

   hawk_page_table table0 (
      .clk        (clk),
      .rst        (rst),
      .xl         (xl0.tbl),
      .fill_valid (fill_valid),
      .fill_page  (fill_page),
      .fill_ppa   (fill_ppa),
      .inactive   (inactive)
   );

endmodule

// ==== source/hawk_xlate_if.sv ====
// Lookup request and grant between the write stall block
// and the page translation table
`timescale 1ns/1ps

interface hawk_xlate_if;

   // Request side, held stable while lookup_valid is high
   logic                             lookup_valid;
   logic [hawk_pkg::PAGE_WIDTH-1:0]  lookup_page;

   // Grant side
   // allow_access pulses once per lookup, ppa_page holds until next grant
   logic                             allow_access;
   logic [hawk_pkg::PAGE_WIDTH-1:0]  ppa_page;

   // Stall block drives the request
   modport stall (
      output lookup_valid,
      output lookup_page,
      input  allow_access,
      input  ppa_page
   );

   // Table answers it
   modport tbl (
      input  lookup_valid,
      input  lookup_page,
      output allow_access,
      output ppa_page
   );

endinterface

// ==== tests/tb_hawk_checks.sv ====
// Checker for the write path: reference translation model,
// expected AW record and the checking assertions
`timescale 1ns/1ps

module tb_hawk_checks (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             inactive,
   input  logic                             fill_valid,
   input  logic [hawk_pkg::PAGE_WIDTH-1:0]  fill_page,
   input  logic [hawk_pkg::PAGE_WIDTH-1:0]  fill_ppa,
   input  logic [hawk_pkg::ID_WIDTH-1:0]    s_axi_awid,
   input  logic [hawk_pkg::ADDR_WIDTH-1:0]  s_axi_awaddr,
   input  logic [7:0]                       s_axi_awlen,
   input  logic [2:0]                       s_axi_awsize,
   input  logic [1:0]                       s_axi_awburst,
   input  logic                             s_axi_awvalid,
   input  logic                             s_axi_awready,
   input  logic [hawk_pkg::DATA_WIDTH-1:0]  s_axi_wdata,
   input  logic [hawk_pkg::STRB_WIDTH-1:0]  s_axi_wstrb,
   input  logic                             s_axi_wlast,
   input  logic                             s_axi_wvalid,
   input  logic                             s_axi_wready,
   input  logic [hawk_pkg::ID_WIDTH-1:0]    s_axi_bid,
   input  logic [1:0]                       s_axi_bresp,
   input  logic                             s_axi_bvalid,
   input  logic                             s_axi_bready,
   input  logic [hawk_pkg::ID_WIDTH-1:0]    m_axi_awid,
   input  logic [hawk_pkg::ADDR_WIDTH-1:0]  m_axi_awaddr,
   input  logic [7:0]                       m_axi_awlen,
   input  logic [2:0]                       m_axi_awsize,
   input  logic [1:0]                       m_axi_awburst,
   input  logic                             m_axi_awvalid,
   input  logic                             m_axi_awready,
   input  logic [hawk_pkg::DATA_WIDTH-1:0]  m_axi_wdata,
   input  logic [hawk_pkg::STRB_WIDTH-1:0]  m_axi_wstrb,
   input  logic                             m_axi_wlast,
   input  logic                             m_axi_wvalid,
   input  logic                             m_axi_wready,
   input  logic [hawk_pkg::ID_WIDTH-1:0]    m_axi_bid,
   input  logic [1:0]                       m_axi_bresp,
   input  logic                             m_axi_bvalid,
   input  logic                             m_axi_bready,
   output logic                             check_error
);

   localparam int PW  = hawk_pkg::PAGE_WIDTH;
   localparam int IXW = hawk_pkg::TABLE_DEPTH_LOG2;

   // Fill model, full page kept per slot
   logic          model_valid [hawk_pkg::TABLE_DEPTH];
   logic [PW-1:0] model_page  [hawk_pkg::TABLE_DEPTH];
   logic [PW-1:0] model_ppa   [hawk_pkg::TABLE_DEPTH];

   // Last address accepted on the CPU side
   logic [hawk_pkg::ID_WIDTH-1:0]    held_id;
   logic [PW-1:0]                    held_page;
   logic [hawk_pkg::PAGE_SHIFT-1:0]  held_offset;
   logic [hawk_pkg::ID_WIDTH+12:0]   held_attr;

   logic          exp_hit;
   logic [PW-1:0] exp_page;
   logic [hawk_pkg::ADDR_WIDTH-1:0]  exp_addr;
   logic [hawk_pkg::ID_WIDTH+12:0]   m_attr;

   initial begin
      check_error = 1'b0;
      for (int i = 0; i < hawk_pkg::TABLE_DEPTH; i++) begin
         model_valid[i] = 1'b0;
      end
   end

   task automatic report_fail(input string name, input logic [127:0] exp, input logic [127:0] act);
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      check_error = 1'b1;
   endtask

   always @(posedge clk) begin
      if (!rst && fill_valid) begin
         model_valid[fill_page[IXW-1:0]] <= 1'b1;
         model_page[fill_page[IXW-1:0]]  <= fill_page;
         model_ppa[fill_page[IXW-1:0]]   <= fill_ppa;
      end
      if (!rst && s_axi_awvalid && s_axi_awready) begin
         held_id     <= s_axi_awid;
         held_page   <= s_axi_awaddr[hawk_pkg::ADDR_WIDTH-1:hawk_pkg::PAGE_SHIFT];
         held_offset <= s_axi_awaddr[hawk_pkg::PAGE_SHIFT-1:0];
         held_attr   <= {s_axi_awid, s_axi_awlen, s_axi_awsize, s_axi_awburst};
      end
   end

   // Inactive wins over any table entry
   assign exp_hit  = inactive || (model_valid[held_page[IXW-1:0]]
                     && model_page[held_page[IXW-1:0]] == held_page);
   assign exp_page = inactive ? held_page : model_ppa[held_page[IXW-1:0]];
   assign exp_addr = {exp_page, held_offset};
   assign m_attr   = {m_axi_awid, m_axi_awlen, m_axi_awsize, m_axi_awburst};

   a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !m_axi_awvalid)
      else report_fail("m_axi_awvalid", 128'(0), 128'($sampled(m_axi_awvalid)));

   a_aw_addr: assert property (@(posedge clk) disable iff (rst)
      m_axi_awvalid && m_axi_awready |-> m_axi_awaddr == exp_addr)
      else report_fail("m_axi_awaddr", 128'($sampled(exp_addr)), 128'($sampled(m_axi_awaddr)));

   a_aw_attr: assert property (@(posedge clk) disable iff (rst)
      m_axi_awvalid && m_axi_awready |-> m_attr == held_attr)
      else report_fail("m_axi_aw id/len/size/burst", 128'($sampled(held_attr)),
                       128'($sampled(m_attr)));

   // No address leaves before its page can be translated
   a_miss_stall: assert property (@(posedge clk) disable iff (rst)
      $rose(m_axi_awvalid) |-> exp_hit)
      else report_fail("m_axi_awvalid", 128'(0), 128'(1));

   a_aw_stable: assert property (@(posedge clk) disable iff (rst)
      m_axi_awvalid && !m_axi_awready |=>
         m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_attr))
      else report_fail("m_axi_awaddr", 128'($past(m_axi_awaddr)), 128'($sampled(m_axi_awaddr)));

   a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
      m_axi_awvalid |-> !s_axi_awready)
      else report_fail("s_axi_awready", 128'(0), 128'($sampled(s_axi_awready)));

   a_w_pass: assert property (@(posedge clk) disable iff (rst)
      {m_axi_wdata, m_axi_wstrb, m_axi_wlast, m_axi_wvalid, s_axi_wready}
      == {s_axi_wdata, s_axi_wstrb, s_axi_wlast, s_axi_wvalid, m_axi_wready})
      else report_fail("m_axi_wdata", 128'($sampled(s_axi_wdata)), 128'($sampled(m_axi_wdata)));

   a_b_pass: assert property (@(posedge clk) disable iff (rst)
      {s_axi_bid, s_axi_bresp, s_axi_bvalid, m_axi_bready}
      == {m_axi_bid, m_axi_bresp, m_axi_bvalid, s_axi_bready})
      else report_fail("s_axi_bid", 128'($sampled(m_axi_bid)), 128'($sampled(s_axi_bid)));

   a_b_id: assert property (@(posedge clk) disable iff (rst)
      s_axi_bvalid && s_axi_bready |-> s_axi_bid == held_id)
      else report_fail("s_axi_bid", 128'($sampled(held_id)), 128'($sampled(s_axi_bid)));

endmodule

// ==== tests/tb_hawk_wr.sv ====
// Testbench top for the write path: clock, reset, AW/W/fill stimulus,
// random AW back-pressure with a B responder, and a watchdog
`timescale 1ns/1ps

module tb_hawk_wr;

   localparam int PW      = hawk_pkg::PAGE_WIDTH;
   localparam int NUM_TXN = 10;

   logic clk;
   logic rst = 1'b1;

   logic [hawk_pkg::ID_WIDTH-1:0]   s_axi_awid, s_axi_bid, m_axi_awid;
   logic [hawk_pkg::ADDR_WIDTH-1:0] s_axi_awaddr, m_axi_awaddr;
   logic [7:0] s_axi_awlen, m_axi_awlen;
   logic [2:0] s_axi_awsize, m_axi_awsize;
   logic [1:0] s_axi_awburst, m_axi_awburst, s_axi_bresp;
   logic       s_axi_awvalid, s_axi_awready, m_axi_awvalid;
   logic [hawk_pkg::DATA_WIDTH-1:0] s_axi_wdata, m_axi_wdata;
   logic [hawk_pkg::STRB_WIDTH-1:0] s_axi_wstrb, m_axi_wstrb;
   logic s_axi_wlast, s_axi_wvalid, s_axi_wready, s_axi_bvalid, s_axi_bready;
   logic m_axi_wlast, m_axi_wvalid, m_axi_bready;
   logic m_axi_wready = 1'b1;

   // Driven by the memory-side responder
   logic                          m_axi_awready = 1'b0;
   logic                          m_axi_bvalid  = 1'b0;
   logic [hawk_pkg::ID_WIDTH-1:0] m_axi_bid     = '0;
   logic [1:0]                    m_axi_bresp   = 2'b00;

   logic          fill_valid, inactive, check_error;
   logic [PW-1:0] fill_page, fill_ppa;

   integer        seed = 19099;
   logic [31:0]   rnd;
   logic [31:0]   stim_rnd;
   logic [7:0]    cur_len;
   logic [PW-1:0] hit_page [4];
   logic [PW-1:0] pg;

   logic [hawk_pkg::ID_WIDTH-1:0] b_ids [$];
   int wlast_count = 0;
   int b_count     = 0;

   hawk_wr_top dut0 (.*);

   tb_hawk_checks checks0 (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      if (!rst && m_axi_wvalid && m_axi_wready && m_axi_wlast) begin
         wlast_count++;
      end
   end

   // Memory side: random awready, one B per completed burst
   always @(negedge clk) begin
      if (!rst) begin
         rnd = $random(seed);
         m_axi_awready = (rnd[1:0] != 2'b00);
         if (m_axi_awvalid && m_axi_awready) begin
            b_ids.push_back(m_axi_awid);
         end
         // bready is tied high, so a raised B was taken on the last edge
         if (m_axi_bvalid) begin
            m_axi_bvalid = 1'b0;
            b_count++;
         end else if (wlast_count > b_count && b_ids.size() > 0) begin
            m_axi_bvalid = 1'b1;
            m_axi_bid    = b_ids.pop_front();
         end
      end
   end

   task automatic do_fill(input logic [PW-1:0] page, input logic [PW-1:0] ppa);
      @(negedge clk);
      fill_valid = 1'b1;
      fill_page  = page;
      fill_ppa   = ppa;
      @(negedge clk);
      fill_valid = 1'b0;
   endtask

   task automatic start_write(input logic [PW-1:0] page);
      stim_rnd = $random(seed);
      cur_len  = {6'b0, stim_rnd[13:12]};
      @(negedge clk);
      s_axi_awid    = stim_rnd[hawk_pkg::ID_WIDTH+15:16];
      s_axi_awaddr  = {page, stim_rnd[hawk_pkg::PAGE_SHIFT-1:0]};
      s_axi_awlen   = cur_len;
      s_axi_awsize  = 3'd3;
      s_axi_awburst = 2'b01;
      s_axi_awvalid = 1'b1;
      while (!s_axi_awready) @(negedge clk);
      @(negedge clk);
      s_axi_awvalid = 1'b0;
   endtask

   task automatic finish_write();
      int nbeats;
      nbeats = int'(cur_len) + 1;
      for (int i = 0; i < nbeats; i++) begin
         @(negedge clk);
         s_axi_wdata  = {$random(seed), $random(seed)};
         s_axi_wstrb  = '1;
         s_axi_wlast  = (i == nbeats - 1);
         s_axi_wvalid = 1'b1;
         while (!s_axi_wready) @(negedge clk);
      end
      @(negedge clk);
      s_axi_wvalid = 1'b0;
      s_axi_wlast  = 1'b0;
      // Response comes back only after the translated AW went out
      @(posedge clk);
      while (!s_axi_bvalid) @(posedge clk);
   endtask

   initial begin
      {s_axi_awid, s_axi_awaddr, s_axi_awlen, s_axi_awsize, s_axi_awburst} = '0;
      {s_axi_awvalid, s_axi_wdata, s_axi_wstrb, s_axi_wlast, s_axi_wvalid} = '0;
      {fill_valid, fill_page, fill_ppa, inactive} = '0;
      s_axi_bready = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Hits, one table slot per filled page
      for (int i = 0; i < 4; i++) begin
         stim_rnd    = $random(seed);
         hit_page[i] = (stim_rnd[PW-1:0] << hawk_pkg::TABLE_DEPTH_LOG2) | PW'(i);
         stim_rnd    = $random(seed);
         do_fill(hit_page[i], stim_rnd[PW-1:0]);
      end
      for (int k = 0; k < 6; k++) begin
         start_write(hit_page[k % 4]);
         finish_write();
      end

      // Misses held until the matching fill
      for (int k = 0; k < 2; k++) begin
         stim_rnd = $random(seed);
         pg = (stim_rnd[PW-1:0] << hawk_pkg::TABLE_DEPTH_LOG2) | PW'(8 + k);
         start_write(pg);
         repeat (20) @(negedge clk);
         stim_rnd = $random(seed);
         do_fill(pg, stim_rnd[PW-1:0]);
         finish_write();
      end

      // Bypass on unfilled slots
      @(negedge clk);
      inactive = 1'b1;
      for (int k = 0; k < 2; k++) begin
         stim_rnd = $random(seed);
         pg = (stim_rnd[PW-1:0] << hawk_pkg::TABLE_DEPTH_LOG2) | PW'(12 + k);
         start_write(pg);
         finish_write();
      end
      @(negedge clk);
      inactive = 1'b0;

      repeat (4) @(negedge clk);
      if (check_error) begin
         $display("RESULT: FAIL");
         $fatal(1, "Checker reported an error");
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

   initial begin
      wait (check_error);
      $display("RESULT: FAIL");
      $fatal(1, "Checker reported an error");
   end

   initial begin
      repeat (8 + 200 * NUM_TXN) @(posedge clk);
      $display("Timeout: transactions did not complete in time");
      $display("RESULT: FAIL");
      $fatal(1, "Watchdog expired");
   end

endmodule
